//--- verilog/rv_pkg.sv
// Shared widths, field types, opcode and funct3 encodings and stage enum for the RV32I core
package rv_pkg;

  parameter int XLEN = 32;
  parameter int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;    // Data word, immediate or PC
  typedef logic [4:0]      reg_idx_t;
  typedef logic [2:0]      funct3_t;  // Doubles as the ALU operation code
  typedef logic [6:0]      opcode_t;

  localparam word_t PC_STEP = 32'd4;

  // Major opcodes
  localparam opcode_t OP_ARITH  = 7'b0110011;
  localparam opcode_t OP_IARITH = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_BRANCH = 7'b1100011;

  // ALU operations, same encoding as the arithmetic funct3
  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  typedef enum logic [1:0] {
    STAGE_FETCH,
    STAGE_DECODE,
    STAGE_READ,
    STAGE_EXEC
  } stage_t;

endpackage

//--- verilog/rv_imem.sv
// Word-addressed instruction memory, loaded through a write port and read combinationally by PC
`timescale 1ns/1ps

module rv_imem #(
  parameter int IMEM_AW = 8
) (
  input  logic               clk,
  input  logic               we,
  input  logic [IMEM_AW-1:0] waddr,
  input  rv_pkg::word_t      wdata,
  input  rv_pkg::word_t      pc,
  output rv_pkg::word_t      instr
);
  import rv_pkg::*;

  word_t mem [0:(1 << IMEM_AW)-1];

  assign instr = mem[pc[IMEM_AW+1:2]];  // Byte offset dropped

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

//--- verilog/rv_decode.sv
// Instruction field slicer and immediate builder, purely combinational
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t    instr,
  output rv_pkg::opcode_t  opcode,
  output rv_pkg::funct3_t  funct3,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output logic             sub,
  output rv_pkg::word_t    imm_i,
  output rv_pkg::word_t    imm_u,
  output rv_pkg::word_t    imm_j,
  output rv_pkg::word_t    imm_b
);
  import rv_pkg::*;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign sub    = instr[30];  // Only meaningful for OP_ARITH

  assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};

  assign imm_u = {instr[31:12], 12'b0};

  // Scrambled J and B layouts, bit 0 always zero
  assign imm_j = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};

endmodule

//--- verilog/rv_regfile.sv
// Integer register file with two combinational read ports and one clocked write port
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             we,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [0:REG_COUNT-1];

  initial begin
    for (int i = 0; i < REG_COUNT; i++) begin
      regs[i] = '0;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin  // x0 never written
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- verilog/rv_alu.sv
// ALU with ripple-carry add/subtract, logic ops and the branch compare flags
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::funct3_t op,
  input  logic            sub,
  output rv_pkg::word_t   res,
  output logic            eq,
  output logic            bge,
  output logic            bgeu
);
  import rv_pkg::*;

  word_t b_in;
  word_t sum;
  logic [XLEN:0] carry;

  assign b_in = sub ? ~b : b;
  assign carry[0] = sub;  // +1 completes the two's complement

  for (genvar i = 0; i < XLEN; i++) begin : g_adder
    assign sum[i] = a[i] ^ b_in[i] ^ carry[i];
    assign carry[i+1] = (a[i] & b_in[i]) | ((a[i] ^ b_in[i]) & carry[i]);
  end

  always_comb begin
    case (op)
      F3_ADD:  res = sum;
      F3_XOR:  res = a ^ b;
      F3_OR:   res = a | b;
      F3_AND:  res = a & b;
      default: res = sum;
    endcase
  end

  assign eq   = (a == b);
  assign bge  = ($signed(a) >= $signed(b));
  assign bgeu = (a >= b);

endmodule

//--- verilog/rv_control.sv
// Multi-cycle stage controller holding PC and IR, sequencing the shared ALU and reporting retires
`timescale 1ns/1ps

module rv_control (
  input  logic             clk,
  input  logic             rstn,
  input  rv_pkg::word_t    instr,
  input  rv_pkg::opcode_t  opcode,
  input  rv_pkg::funct3_t  funct3,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             sub,
  input  rv_pkg::word_t    imm_i,
  input  rv_pkg::word_t    imm_u,
  input  rv_pkg::word_t    imm_j,
  input  rv_pkg::word_t    imm_b,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    alu_res,
  input  logic             alu_eq,
  input  logic             alu_bge,
  input  logic             alu_bgeu,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    ir,
  output rv_pkg::reg_idx_t rf_rs1,
  output rv_pkg::reg_idx_t rf_rs2,
  output rv_pkg::reg_idx_t rf_rd,
  output logic             rf_we,
  output rv_pkg::word_t    rf_data,
  output rv_pkg::word_t    alu_a,
  output rv_pkg::word_t    alu_b,
  output rv_pkg::funct3_t  alu_op,
  output logic             alu_sub,
  output logic             retire_valid,
  output rv_pkg::word_t    retire_pc,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::word_t    retire_data
);
  import rv_pkg::*;

  stage_t stage;
  word_t  seq_pc;  // PC plus 4, also the JAL link value
  word_t  target;  // Branch target
  logic   known_op;
  logic   retire_now;
  logic   writes_rd;
  logic   taken;
  word_t  wb_data;

  assign known_op = (opcode == OP_ARITH) || (opcode == OP_IARITH) || (opcode == OP_LUI) ||
                    (opcode == OP_JAL) || (opcode == OP_BRANCH);

  always_comb begin
    retire_now = 1'b0;
    writes_rd  = 1'b0;
    wb_data    = alu_res;
    case (stage)
      STAGE_DECODE: begin
        if (opcode == OP_LUI) begin
          retire_now = 1'b1;
          writes_rd  = 1'b1;
          wb_data    = imm_u;
        end else if (!known_op) begin
          retire_now = 1'b1;  // Unsupported opcode retires as a no-op
        end
      end
      STAGE_READ: begin
        if (opcode == OP_JAL) begin
          retire_now = 1'b1;
          writes_rd  = 1'b1;
          wb_data    = seq_pc;
        end
      end
      STAGE_EXEC: begin
        retire_now = 1'b1;
        writes_rd  = (opcode != OP_BRANCH);
      end
      default: ;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = alu_eq;
      F3_BNE:  taken = !alu_eq;
      F3_BLT:  taken = !alu_bge;
      F3_BGE:  taken = alu_bge;
      F3_BLTU: taken = !alu_bgeu;
      F3_BGEU: taken = alu_bgeu;
      default: taken = 1'b0;
    endcase
  end

  assign rf_rs1  = rs1;
  assign rf_rs2  = rs2;
  assign rf_rd   = rd;
  assign rf_we   = retire_now & writes_rd;  // Write lands on the retire edge
  assign rf_data = wb_data;

  always_ff @(posedge clk) begin
    if (rstn) begin
      stage        <= STAGE_FETCH;
      pc           <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire_now;
      case (stage)
        STAGE_FETCH: stage <= STAGE_DECODE;
        STAGE_DECODE: begin
          if (retire_now) begin
            pc    <= alu_res;
            stage <= STAGE_FETCH;
          end else begin
            stage <= STAGE_READ;
          end
        end
        STAGE_READ: begin
          if (opcode == OP_JAL) begin
            pc    <= alu_res;  // PC + imm_j
            stage <= STAGE_FETCH;
          end else begin
            stage <= STAGE_EXEC;
          end
        end
        default: begin
          pc    <= (opcode == OP_BRANCH && taken) ? target : seq_pc;
          stage <= STAGE_FETCH;
        end
      endcase
    end
  end

  // Datapath and retire payload
  always_ff @(posedge clk) begin
    retire_pc   <= pc;
    retire_rd   <= rf_we ? rd : '0;
    retire_data <= (rf_we && rd != '0) ? wb_data : '0;
    case (stage)
      STAGE_FETCH: begin
        ir      <= instr;
        alu_a   <= pc;
        alu_b   <= PC_STEP;
        alu_op  <= F3_ADD;
        alu_sub <= 1'b0;
      end
      STAGE_DECODE: begin
        seq_pc <= alu_res;
        alu_a  <= pc;
        alu_b  <= (opcode == OP_JAL) ? imm_j : imm_b;
      end
      STAGE_READ: begin
        target  <= alu_res;
        alu_a   <= rs1_data;
        alu_b   <= (opcode == OP_IARITH) ? imm_i : rs2_data;
        alu_op  <= funct3;
        alu_sub <= (opcode == OP_ARITH) && sub;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/rv_core.sv
// Top level of the multi-cycle RV32I core with program load port and retire report
`timescale 1ns/1ps

module rv_core #(
  parameter int IMEM_AW = 8
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               imem_we,
  input  logic [IMEM_AW-1:0] imem_addr,
  input  rv_pkg::word_t      imem_wdata,
  output logic               retire_valid,
  output rv_pkg::word_t      retire_pc,
  output rv_pkg::reg_idx_t   retire_rd,
  output rv_pkg::word_t      retire_data
);
  import rv_pkg::*;

  word_t    pc, instr, ir;
  opcode_t  opcode;
  funct3_t  funct3, alu_op;
  reg_idx_t rd, rs1, rs2, rf_rs1, rf_rs2, rf_rd;
  logic     sub, rf_we, alu_sub, alu_eq, alu_bge, alu_bgeu;
  word_t    imm_i, imm_u, imm_j, imm_b;
  word_t    rs1_data, rs2_data, rf_data;
  word_t    alu_a, alu_b, alu_res;

  rv_imem #(.IMEM_AW(IMEM_AW)) i_imem (
    .clk(clk), .we(imem_we), .waddr(imem_addr), .wdata(imem_wdata), .pc(pc), .instr(instr)
  );

  rv_decode i_decode (
    .instr(ir), .opcode(opcode), .funct3(funct3), .rd(rd), .rs1(rs1), .rs2(rs2), .sub(sub),
    .imm_i(imm_i), .imm_u(imm_u), .imm_j(imm_j), .imm_b(imm_b)
  );

  rv_regfile i_regfile (
    .clk(clk), .we(rf_we), .rs1(rf_rs1), .rs2(rf_rs2), .rd(rf_rd), .rd_data(rf_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_alu i_alu (
    .a(alu_a), .b(alu_b), .op(alu_op), .sub(alu_sub),
    .res(alu_res), .eq(alu_eq), .bge(alu_bge), .bgeu(alu_bgeu)
  );

  rv_control i_control (
    .clk(clk), .rstn(rstn), .instr(instr), .opcode(opcode), .funct3(funct3), .rd(rd),
    .rs1(rs1), .rs2(rs2), .sub(sub), .imm_i(imm_i), .imm_u(imm_u), .imm_j(imm_j),
    .imm_b(imm_b), .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_res(alu_res),
    .alu_eq(alu_eq), .alu_bge(alu_bge), .alu_bgeu(alu_bgeu), .pc(pc), .ir(ir),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rd(rf_rd), .rf_we(rf_we), .rf_data(rf_data),
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_sub(alu_sub),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_data(retire_data)
  );

endmodule

//--- verification/tb_clock.sv
// Free-running testbench clock, 10 ns period with the first rising edge at 5 ns
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- verification/rv_control_props.sv
// Concurrent retire and reset checks that the testbench binds into rv_control
`timescale 1ns/1ps

module rv_control_props (
  input logic             clk,
  input logic             rstn,
  input logic             retire_now,
  input rv_pkg::opcode_t  opcode,
  input logic             rf_we,
  input logic             retire_valid,
  input rv_pkg::reg_idx_t retire_rd
);
  import rv_pkg::*;

  // Retire is a one-cycle pulse
  assert property (@(posedge clk) disable iff (rstn) retire_valid |=> !retire_valid)
    else $error("retire_valid high in two consecutive cycles");

  // Quiet in reset once the first reset edge has passed
  assert property (@(posedge clk) (rstn && $past(rstn)) |-> (!retire_valid && !rf_we))
    else $error("retire_valid or rf_we high while rstn is set");

  // A branch writes no register and reports rd 0
  assert property (@(posedge clk) disable iff (rstn)
                   (retire_now && opcode == OP_BRANCH) |=> (!$past(rf_we) && retire_rd == '0))
    else $error("branch retire wrote a register or reported a nonzero rd");

endmodule

//--- verification/rv_core_tb.sv
// Testbench for rv_core that loads a program, steps an ISA model of it and compares every retire
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int          IMEM_AW         = 8;
  localparam int          RESET_CYCLES    = 16;
  localparam int          RAND_COUNT      = 60;
  localparam int          RETIRE_TIMEOUT  = 20;
  localparam int          RELEASE_TIMEOUT = 1000;
  localparam int unsigned SEED            = 32'ha17d9c0b;

  logic               clk;
  logic               rstn;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_addr;
  word_t              imem_wdata;
  logic               retire_valid;
  word_t              retire_pc;
  reg_idx_t           retire_rd;
  word_t              retire_data;

  word_t   prog [0:(1 << IMEM_AW)-1];  // Program image shared with the model
  int      prog_len = 0;
  word_t   model_regs [0:REG_COUNT-1];
  word_t   model_pc;
  int      value_errors = 0;
  int      other_errors = 0;
  funct3_t alu_codes [0:3] = '{F3_ADD, F3_XOR, F3_OR, F3_AND};
  funct3_t branch_codes [0:5] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  tb_clock i_clock (.clk(clk));

  rv_core #(.IMEM_AW(IMEM_AW)) i_dut (
    .clk(clk), .rstn(rstn), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data)
  );

  bind rv_control rv_control_props i_props (
    .clk(clk), .rstn(rstn), .retire_now(retire_now), .opcode(opcode), .rf_we(rf_we),
    .retire_valid(retire_valid), .retire_rd(retire_rd)
  );

  function automatic word_t r_type(logic alt, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                   funct3_t f3);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_ARITH};
  endfunction

  function automatic word_t i_type(reg_idx_t rd, reg_idx_t rs1, funct3_t f3, logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IARITH};
  endfunction

  function automatic word_t u_type(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t b_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  task automatic append(word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    word_t r;
    int    c;
    int    sel;
    int    hop;
    int    halt_idx;
    append(i_type(5'd1, 5'd0, F3_ADD, 12'hfff));  // x1 = -1
    append(i_type(5'd2, 5'd0, F3_ADD, 12'h001));
    append(r_type(1'b0, 5'd3, 5'd1, 5'd2, F3_ADD));  // Carry out of bit 31
    append(u_type(5'd4, 20'h80000));
    append(r_type(1'b0, 5'd5, 5'd4, 5'd4, F3_ADD));
    append(r_type(1'b1, 5'd6, 5'd2, 5'd1, F3_ADD));
    append(r_type(1'b1, 5'd7, 5'd0, 5'd2, F3_ADD));  // Result below zero
    append(u_type(5'd8, 20'h12345));
    append(i_type(5'd8, 5'd8, F3_ADD, 12'h678));
    append(u_type(5'd9, 20'hf0f0f));
    append(i_type(5'd9, 5'd9, F3_ADD, 12'h0f0));
    append(r_type(1'b0, 5'd10, 5'd8, 5'd9, F3_XOR));
    append(r_type(1'b0, 5'd11, 5'd8, 5'd9, F3_OR));
    append(r_type(1'b0, 5'd12, 5'd8, 5'd9, F3_AND));
    append(i_type(5'd13, 5'd8, F3_XOR, 12'hfff));
    append(i_type(5'd14, 5'd2, F3_OR, 12'h800));
    append(i_type(5'd15, 5'd9, F3_AND, 12'hff0));
    append(i_type(5'd0, 5'd2, F3_ADD, 12'h005));  // Write to x0
    append(r_type(1'b0, 5'd16, 5'd0, 5'd0, F3_ADD));
    append(u_type(5'd17, 20'habcde));
    // Operand pairs (-1, 1), (1, -1) and (1, 1) with a filler skipped when taken
    for (c = 0; c < 6; c++) begin
      append(b_type(branch_codes[c], 5'd1, 5'd2, 13'd8));
      append(i_type(5'd20, 5'd20, F3_ADD, 12'h001));
      append(b_type(branch_codes[c], 5'd2, 5'd1, 13'd8));
      append(i_type(5'd20, 5'd20, F3_ADD, 12'h001));
      append(b_type(branch_codes[c], 5'd2, 5'd2, 13'd8));
      append(i_type(5'd20, 5'd20, F3_ADD, 12'h001));
    end
    append(j_type(5'd21, 21'd8));
    append(i_type(5'd20, 5'd20, F3_ADD, 12'h001));
    halt_idx = prog_len + RAND_COUNT;
    for (c = 0; c < RAND_COUNT; c++) begin
      r   = $urandom();
      sel = $urandom_range(9, 0);
      hop = $urandom_range((halt_idx - prog_len < 4) ? halt_idx - prog_len : 4, 1);
      case (sel)
        0, 1, 2: append(r_type(r[20] && (r[16:15] == 2'b00), r[4:0], r[9:5], r[14:10],
                               alu_codes[r[16:15]]));
        3, 4, 5: append(i_type(r[4:0], r[9:5], alu_codes[r[16:15]], r[31:20]));
        6:       append(u_type(r[4:0], r[31:12]));
        7:       append(j_type(r[4:0], 21'(hop * 4)));  // Forward only
        default: append(b_type(branch_codes[$urandom_range(5, 0)], r[9:5], r[14:10],
                               13'(hop * 4)));
      endcase
    end
    append(j_type(5'd0, 21'd0));  // Halt loop
  endtask

  // ISA model step returning the retire record of one instruction
  function automatic void model_step(output word_t pc_o, output reg_idx_t rd_o,
                                     output word_t data_o);
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    res;
    word_t    next_pc;
    reg_idx_t rd;
    logic     writes;
    logic     taken;
    ins     = prog[model_pc[IMEM_AW+1:2]];
    rd      = ins[11:7];
    a       = model_regs[ins[19:15]];
    b       = (ins[6:0] == OP_IARITH) ? {{20{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
    next_pc = model_pc + 32'd4;
    writes  = 1'b1;
    res     = '0;
    taken   = 1'b0;
    case (ins[6:0])
      OP_ARITH, OP_IARITH: begin
        case (ins[14:12])
          F3_XOR:  res = a ^ b;
          F3_OR:   res = a | b;
          F3_AND:  res = a & b;
          default: res = (ins[6:0] == OP_ARITH && ins[30]) ? a - b : a + b;
        endcase
      end
      OP_LUI: res = {ins[31:12], 12'h000};
      OP_JAL: begin
        res     = next_pc;
        next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      OP_BRANCH: begin
        writes = 1'b0;
        case (ins[14:12])
          F3_BEQ:  taken = (a == b);
          F3_BNE:  taken = (a != b);
          F3_BLT:  taken = ($signed(a) < $signed(b));
          F3_BGE:  taken = ($signed(a) >= $signed(b));
          F3_BLTU: taken = (a < b);
          F3_BGEU: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: writes = 1'b0;
    endcase
    pc_o   = model_pc;
    rd_o   = writes ? rd : 5'd0;
    data_o = (writes && rd != 5'd0) ? res : 32'd0;
    if (writes && rd != 5'd0) begin
      model_regs[rd] = res;
    end
    model_pc = next_pc;
  endfunction

  task automatic check_value(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic wait_retire(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < RETIRE_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = (retire_valid === 1'b1);
    end
  endtask

  // Program load while in reset and then release
  initial begin
    int i;
    void'($urandom(SEED));
    rstn       = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    build_program();
    for (i = 0; i < prog_len || i < RESET_CYCLES; i++) begin
      @(posedge clk);
      imem_we    <= (i < prog_len);
      imem_addr  <= IMEM_AW'(i);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    rstn    <= 1'b0;
  end

  // Comparator and final report
  initial begin
    word_t    exp_pc;
    word_t    exp_data;
    reg_idx_t exp_rd;
    int       n;
    int       halt_hits;
    bit       seen;
    halt_hits = 0;
    seen      = 1'b1;
    for (n = 0; n < RELEASE_TIMEOUT && rstn !== 1'b0; n++) begin
      @(negedge clk);
      if (retire_valid !== 1'b0) begin
        $display("Retire reported while the core was held in reset at %0t", $time);
        other_errors++;
      end
    end
    if (rstn !== 1'b0) begin
      $display("Reset was never released");
      other_errors++;
    end else begin
      model_pc = '0;  // First retire must come from address 0
      for (n = 0; n < REG_COUNT; n++) begin
        model_regs[n] = '0;
      end
      while (halt_hits < 3 && seen) begin
        wait_retire(seen);
        if (!seen) begin
          $display("No retire within %0d cycles, model PC 0x%08h", RETIRE_TIMEOUT, model_pc);
          other_errors++;
        end else begin
          model_step(exp_pc, exp_rd, exp_data);
          check_value("retire_pc", retire_pc, exp_pc);
          check_value("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
          check_value("retire_data", retire_data, exp_data);
          if (model_pc == exp_pc) begin
            halt_hits++;
          end
        end
      end
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
verilog/rv_pkg.sv
verilog/rv_imem.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_control.sv
verilog/rv_core.sv
verification/tb_clock.sv
verification/rv_control_props.sv
verification/rv_core_tb.sv

//--- Makefile
SIM      := verilator
TOP      := rv_core_tb
FILELIST := files.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir
LOG      := sim.log
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SHELL    := /bin/bash

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	set -o pipefail; ./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
